//--- hdl/priv_consts.svh
`ifndef PRIV_CONSTS_SVH
`define PRIV_CONSTS_SVH

// Set to "disabled" to build an M/U only core.
`define SUPERVISOR_ENABLED "enabled"

// Machine level CSR addresses.
`define CSR_MSTATUS  12'h300
`define CSR_MEDELEG  12'h302
`define CSR_MIDELEG  12'h303
`define CSR_MIE      12'h304
`define CSR_MTVEC    12'h305
`define CSR_MEPC     12'h341
`define CSR_MCAUSE   12'h342
`define CSR_MIP      12'h344

// Supervisor level CSR addresses.
`define CSR_SSTATUS  12'h100
`define CSR_SIE      12'h104
`define CSR_STVEC    12'h105
`define CSR_SEPC     12'h141
`define CSR_SCAUSE   12'h142

// Cause codes.
`define CAUSE_ILLEGAL_INSN  5'd2
`define CAUSE_M_SOFT        5'd3
`define CAUSE_M_TIMER       5'd7
`define CAUSE_S_EXT         5'd9
`define CAUSE_M_EXT         5'd11

`define RESET_VECTOR  32'h0000_0100  // Reset value of mtvec.

`endif

//--- hdl/priv_types_pkg.sv
package priv_types_pkg;

    // Encodings follow the mstatus.mpp field.
    typedef enum logic [1:0] {
        U_MODE = 2'b00,
        S_MODE = 2'b01,
        M_MODE = 2'b11
    } priv_level_t;

    // Event committed by the controller this cycle.
    typedef enum logic [2:0] {
        EV_NONE,
        EV_EXC,
        EV_INTR,
        EV_MRET,
        EV_SRET
    } trap_ev_t;

    // CSR instruction flavour.
    typedef enum logic [1:0] {
        CSR_RD,  // Read only, no write.
        CSR_RW,
        CSR_RS,
        CSR_RC
    } csr_op_t;

endpackage

//--- hdl/priv_mode.sv
`include "priv_consts.svh"

module priv_mode (
    input  logic                        CLK, nRST,
    input  priv_types_pkg::trap_ev_t    ev,
    input  logic                        trap_to_s,
    input  priv_types_pkg::priv_level_t mpp,
    input  logic                        spp,
    output priv_types_pkg::priv_level_t priv_level,
    output logic                        is_u, is_s, is_m
);

    localparam bit SUP = (`SUPERVISOR_ENABLED == "enabled");

    priv_types_pkg::priv_level_t curr_level, next_level;

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            curr_level <= priv_types_pkg::M_MODE;  // Boot in machine mode.
        end else begin
            curr_level <= next_level;
        end
    end

    always_comb begin
        next_level = curr_level;
        case (ev)
            priv_types_pkg::EV_EXC, priv_types_pkg::EV_INTR:
                next_level = (trap_to_s && SUP) ? priv_types_pkg::S_MODE : priv_types_pkg::M_MODE;
            priv_types_pkg::EV_MRET: begin
                next_level = mpp;
                if (mpp == priv_types_pkg::S_MODE && !SUP) next_level = priv_types_pkg::U_MODE;
            end
            priv_types_pkg::EV_SRET:
                next_level = (spp && SUP) ? priv_types_pkg::S_MODE : priv_types_pkg::U_MODE;
            default: ;  // Hold level.
        endcase
    end

    assign priv_level = curr_level;
    assign is_u = curr_level == priv_types_pkg::U_MODE;
    assign is_s = (curr_level == priv_types_pkg::S_MODE) && SUP;  // Never set without S.
    assign is_m = curr_level == priv_types_pkg::M_MODE;

endmodule

//--- hdl/priv_intr_pick.sv
`include "priv_consts.svh"

module priv_intr_pick (
    input  logic                        irq_m_ext, irq_m_timer, irq_m_soft, irq_s_ext,
    input  logic [31:0]                 mie_reg,
    input  logic [31:0]                 mideleg,
    input  logic                        mstatus_mie, mstatus_sie,
    input  priv_types_pkg::priv_level_t priv_level,
    output logic                        intr_pend,
    output logic [4:0]                  intr_cause,
    output logic                        intr_to_s
);

    localparam bit SUP = (`SUPERVISOR_ENABLED == "enabled");

    logic [31:0] mip, pend, deleg, m_grp, s_grp, avail;
    logic        m_en, s_en;

    // MEIP 11, SEIP 9, MTIP 7, MSIP 3.
    assign mip = {20'b0, irq_m_ext, 1'b0, irq_s_ext, 1'b0, irq_m_timer, 3'b0, irq_m_soft, 3'b0};
    assign pend = mip & mie_reg;
    assign deleg = SUP ? mideleg : 32'b0;  // No delegation without S.

    // Global enables at the current level.
    assign m_en = (priv_level != priv_types_pkg::M_MODE) || mstatus_mie;
    assign s_en = (priv_level == priv_types_pkg::U_MODE) ||
                  ((priv_level == priv_types_pkg::S_MODE) && mstatus_sie);

    assign m_grp = pend & ~deleg & {32{m_en}};
    assign s_grp = pend & deleg & {32{s_en}};
    assign avail = m_grp | s_grp;

    // Fixed priority encoder.
    always_comb begin
        intr_pend = 1'b1;
        intr_cause = 5'd0;
        if (avail[11]) begin
            intr_cause = `CAUSE_M_EXT;
        end else if (avail[3]) begin
            intr_cause = `CAUSE_M_SOFT;
        end else if (avail[7]) begin
            intr_cause = `CAUSE_M_TIMER;
        end else if (avail[9]) begin
            intr_cause = `CAUSE_S_EXT;
        end else begin
            intr_pend = 1'b0;  // Nothing to take.
        end
    end

    assign intr_to_s = intr_pend && deleg[intr_cause];  // Goes to S when delegated.

endmodule

//--- hdl/priv_csr_file.sv
`include "priv_consts.svh"

module priv_csr_file (
    input  logic                        CLK, nRST,
    input  logic                        csr_valid,
    input  priv_types_pkg::csr_op_t     csr_op,
    input  logic [11:0]                 csr_addr,
    input  logic [31:0]                 csr_wdata,
    input  priv_types_pkg::priv_level_t priv_level,
    input  priv_types_pkg::trap_ev_t    ev,
    input  logic [4:0]                  trap_cause,
    input  logic                        trap_is_intr, trap_to_s,
    input  logic [31:0]                 epc,
    input  logic                        irq_m_ext, irq_m_timer, irq_m_soft, irq_s_ext,
    output logic [31:0]                 csr_rdata,
    output logic                        csr_illegal,
    output priv_types_pkg::priv_level_t mpp,
    output logic                        spp, mstatus_mie, mstatus_sie,
    output logic [31:0]                 mepc, sepc, mtvec, stvec,
    output logic [31:0]                 medeleg, mie_reg, mideleg
);

    localparam bit SUP = (`SUPERVISOR_ENABLED == "enabled");
    localparam logic [31:0] SIE_MASK = 32'h0000_0222;  // SSIE, STIE, SEIE.

    logic        mpie, spie;
    logic [31:0] mcause, scause, mip, mstatus, sstatus;
    logic [31:0] wval;
    logic        known, do_write;
    priv_types_pkg::priv_level_t mpp_w;

    assign mip = {20'b0, irq_m_ext, 1'b0, irq_s_ext, 1'b0, irq_m_timer, 3'b0, irq_m_soft, 3'b0};
    assign mstatus = {19'b0, mpp, 2'b0, spp, mpie, 1'b0, spie, 1'b0, mstatus_mie, 1'b0,
                      mstatus_sie, 1'b0};
    assign sstatus = {23'b0, spp, 2'b0, spie, 3'b0, mstatus_sie, 1'b0};  // S view.

    // Read mux, unknown addresses read zero.
    always_comb begin
        known = 1'b1;
        csr_rdata = 32'b0;
        case (csr_addr)
            `CSR_MSTATUS: csr_rdata = mstatus;
            `CSR_MEDELEG: csr_rdata = medeleg;
            `CSR_MIDELEG: csr_rdata = mideleg;
            `CSR_MIE:     csr_rdata = mie_reg;
            `CSR_MTVEC:   csr_rdata = mtvec;
            `CSR_MEPC:    csr_rdata = mepc;
            `CSR_MCAUSE:  csr_rdata = mcause;
            `CSR_MIP:     csr_rdata = mip;
            `CSR_SSTATUS: begin known = SUP; csr_rdata = SUP ? sstatus : 32'b0; end
            `CSR_SIE:     begin known = SUP; csr_rdata = SUP ? (mie_reg & SIE_MASK) : 32'b0; end
            `CSR_STVEC:   begin known = SUP; csr_rdata = SUP ? stvec : 32'b0; end
            `CSR_SEPC:    begin known = SUP; csr_rdata = SUP ? sepc : 32'b0; end
            `CSR_SCAUSE:  begin known = SUP; csr_rdata = SUP ? scause : 32'b0; end
            default:      known = 1'b0;
        endcase
    end

    // Bits [9:8] carry the lowest level allowed to touch the CSR.
    assign csr_illegal = csr_valid && (!known || (csr_addr[9:8] > priv_level));
    assign do_write = csr_valid && !csr_illegal && (csr_op != priv_types_pkg::CSR_RD);

    always_comb begin
        case (csr_op)
            priv_types_pkg::CSR_RW: wval = csr_wdata;
            priv_types_pkg::CSR_RS: wval = csr_rdata | csr_wdata;
            priv_types_pkg::CSR_RC: wval = csr_rdata & ~csr_wdata;
            default:                wval = csr_rdata;
        endcase
        // mpp only holds legal levels.
        mpp_w = priv_types_pkg::priv_level_t'(wval[12:11]);
        if (wval[12:11] == 2'b10 || (mpp_w == priv_types_pkg::S_MODE && !SUP))
            mpp_w = priv_types_pkg::U_MODE;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            mpp <= priv_types_pkg::U_MODE;
            {spp, mpie, spie, mstatus_mie, mstatus_sie} <= '0;
            {mepc, sepc, mcause, scause, stvec} <= '0;
            {medeleg, mideleg, mie_reg} <= '0;
            mtvec <= `RESET_VECTOR;
        end else if (ev == priv_types_pkg::EV_EXC || ev == priv_types_pkg::EV_INTR) begin
            if (trap_to_s) begin
                sepc <= epc;
                scause <= {trap_is_intr, 26'b0, trap_cause};
                spp <= priv_level[0];  // S is 1, U is 0.
                spie <= mstatus_sie;
                mstatus_sie <= 1'b0;
            end else begin
                mepc <= epc;
                mcause <= {trap_is_intr, 26'b0, trap_cause};
                mpp <= priv_level;
                mpie <= mstatus_mie;
                mstatus_mie <= 1'b0;
            end
        end else if (ev == priv_types_pkg::EV_MRET) begin
            mstatus_mie <= mpie;
            mpie <= 1'b1;
            mpp <= priv_types_pkg::U_MODE;
        end else if (ev == priv_types_pkg::EV_SRET) begin
            mstatus_sie <= spie;
            spp <= 1'b0;
        end else if (do_write) begin
            case (csr_addr)
                `CSR_MSTATUS: begin
                    mpp <= mpp_w;
                    {spp, mpie, spie} <= {wval[8] & SUP, wval[7], wval[5]};
                    {mstatus_mie, mstatus_sie} <= {wval[3], wval[1]};
                end
                `CSR_SSTATUS: {spp, spie, mstatus_sie} <= {wval[8], wval[5], wval[1]};
                `CSR_MEDELEG: medeleg <= wval;
                `CSR_MIDELEG: mideleg <= wval;
                `CSR_MIE:     mie_reg <= wval;
                `CSR_SIE:     mie_reg <= (mie_reg & ~SIE_MASK) | (wval & SIE_MASK);
                `CSR_MTVEC:   mtvec <= wval;
                `CSR_MEPC:    mepc <= wval;
                `CSR_MCAUSE:  mcause <= wval;
                `CSR_STVEC:   stvec <= wval;
                `CSR_SEPC:    sepc <= wval;
                `CSR_SCAUSE:  scause <= wval;
                default: ;  // mip is read only.
            endcase
        end
    end

endmodule

//--- hdl/priv_trap_ctrl.sv
`include "priv_consts.svh"

module priv_trap_ctrl (
    input  logic                        CLK, nRST,
    input  logic                        exc,
    input  logic [4:0]                  exc_cause,
    input  logic                        mret, sret,
    input  logic                        csr_illegal,
    input  logic                        intr_pend,
    input  logic [4:0]                  intr_cause,
    input  logic                        intr_to_s,
    input  logic [31:0]                 medeleg,
    input  priv_types_pkg::priv_level_t priv_level,
    input  logic [31:0]                 mtvec, stvec, mepc, sepc,
    output priv_types_pkg::trap_ev_t    ev,
    output logic [4:0]                  trap_cause,
    output logic                        trap_is_intr, trap_to_s,
    output logic                        redirect,
    output logic [31:0]                 redirect_pc
);

    localparam bit SUP = (`SUPERVISOR_ENABLED == "enabled");

    logic [31:0] target_pc;

    // One event per cycle, fixed priority.
    always_comb begin
        ev = priv_types_pkg::EV_NONE;
        trap_cause = 5'd0;
        trap_is_intr = 1'b0;
        trap_to_s = 1'b0;
        if (csr_illegal) begin
            ev = priv_types_pkg::EV_EXC;
            trap_cause = `CAUSE_ILLEGAL_INSN;
        end else if (exc) begin
            ev = priv_types_pkg::EV_EXC;
            trap_cause = exc_cause;
        end else if (intr_pend) begin
            ev = priv_types_pkg::EV_INTR;
            trap_cause = intr_cause;
            trap_is_intr = 1'b1;
            trap_to_s = intr_to_s;  // Delegation decided by the picker.
        end else if (mret) begin
            ev = priv_types_pkg::EV_MRET;
        end else if (sret) begin
            ev = priv_types_pkg::EV_SRET;
        end
        // Exceptions from below M may be handed to S.
        if (ev == priv_types_pkg::EV_EXC)
            trap_to_s = SUP && (priv_level != priv_types_pkg::M_MODE) && medeleg[trap_cause];
    end

    always_comb begin
        case (ev)
            priv_types_pkg::EV_EXC, priv_types_pkg::EV_INTR:
                target_pc = trap_to_s ? {stvec[31:2], 2'b00} : {mtvec[31:2], 2'b00};
            priv_types_pkg::EV_MRET: target_pc = mepc;
            priv_types_pkg::EV_SRET: target_pc = sepc;
            default:                 target_pc = redirect_pc;  // Hold.
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            redirect <= 1'b0;
        end else begin
            redirect <= ev != priv_types_pkg::EV_NONE;  // One cycle pulse.
        end
    end

    always_ff @(posedge CLK) begin
        redirect_pc <= target_pc;  // Valid with redirect.
    end

endmodule

//--- hdl/priv_block.sv
module priv_block (
    input  logic                        CLK, nRST,
    input  logic                        exc,
    input  logic [4:0]                  exc_cause,
    input  logic [31:0]                 epc,
    input  logic                        mret, sret,
    input  logic                        csr_valid,
    input  priv_types_pkg::csr_op_t     csr_op,
    input  logic [11:0]                 csr_addr,
    input  logic [31:0]                 csr_wdata,
    output logic [31:0]                 csr_rdata,
    input  logic                        irq_m_ext, irq_m_timer, irq_m_soft, irq_s_ext,
    output logic                        redirect,
    output logic [31:0]                 redirect_pc,
    output priv_types_pkg::priv_level_t priv_level,
    output logic                        is_u, is_s, is_m
);

    priv_types_pkg::trap_ev_t    ev;
    priv_types_pkg::priv_level_t mpp;
    logic [4:0]  trap_cause, intr_cause;
    logic        trap_is_intr, trap_to_s;
    logic        intr_pend, intr_to_s, csr_illegal;
    logic        spp, mstatus_mie, mstatus_sie;
    logic [31:0] mepc, sepc, mtvec, stvec, medeleg, mie_reg, mideleg;

    priv_mode mode0 (
        .CLK, .nRST, .ev, .trap_to_s, .mpp, .spp,
        .priv_level, .is_u, .is_s, .is_m
    );

    priv_intr_pick pick0 (
        .irq_m_ext, .irq_m_timer, .irq_m_soft, .irq_s_ext,
        .mie_reg, .mideleg, .mstatus_mie, .mstatus_sie, .priv_level,
        .intr_pend, .intr_cause, .intr_to_s
    );

    // CSR storage and trap-time field updates.
    priv_csr_file csr0 (
        .CLK, .nRST, .csr_valid, .csr_op, .csr_addr, .csr_wdata,
        .priv_level, .ev, .trap_cause, .trap_is_intr, .trap_to_s, .epc,
        .irq_m_ext, .irq_m_timer, .irq_m_soft, .irq_s_ext,
        .csr_rdata, .csr_illegal, .mpp, .spp, .mstatus_mie, .mstatus_sie,
        .mepc, .sepc, .mtvec, .stvec, .medeleg, .mie_reg, .mideleg
    );

    priv_trap_ctrl ctrl0 (
        .CLK, .nRST, .exc, .exc_cause, .mret, .sret, .csr_illegal,
        .intr_pend, .intr_cause, .intr_to_s, .medeleg, .priv_level,
        .mtvec, .stvec, .mepc, .sepc,
        .ev, .trap_cause, .trap_is_intr, .trap_to_s, .redirect, .redirect_pc
    );

endmodule

//--- sim/priv_block_tb.sv
`include "priv_consts.svh"

module priv_block_tb;

    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 16;
    localparam int MARGIN_CYCLES = 10;  // Slack on top of the table length.

    localparam priv_types_pkg::priv_level_t LVL_M = priv_types_pkg::M_MODE;
    localparam priv_types_pkg::priv_level_t LVL_S = priv_types_pkg::S_MODE;
    localparam priv_types_pkg::priv_level_t LVL_U = priv_types_pkg::U_MODE;
    localparam priv_types_pkg::csr_op_t OP_RD = priv_types_pkg::CSR_RD;
    localparam priv_types_pkg::csr_op_t OP_RW = priv_types_pkg::CSR_RW;
    localparam priv_types_pkg::csr_op_t OP_RS = priv_types_pkg::CSR_RS;
    localparam priv_types_pkg::csr_op_t OP_RC = priv_types_pkg::CSR_RC;

    // One table row: stimulus for one cycle, then what should follow.
    typedef struct packed {
        logic                        exc;
        logic [4:0]                  cause;
        logic [31:0]                 epc;
        logic                        mret;
        logic                        sret;
        logic                        csr_valid;
        priv_types_pkg::csr_op_t     op;
        logic [11:0]                 addr;
        logic [31:0]                 wdata;
        logic [3:0]                  irq;        // {m_ext, m_timer, m_soft, s_ext}.
        logic                        chk_rdata;  // Same cycle read check.
        logic [31:0]                 exp_rdata;
        logic                        exp_redir;  // Pulse after the next edge.
        logic [31:0]                 exp_pc;
        priv_types_pkg::priv_level_t exp_lvl;
    } row_t;

    logic CLK, nRST;
    logic exc, mret, sret, csr_valid;
    logic [4:0] exc_cause;
    logic [31:0] epc, csr_wdata, csr_rdata, redirect_pc;
    priv_types_pkg::csr_op_t csr_op;
    logic [11:0] csr_addr;
    logic irq_m_ext, irq_m_timer, irq_m_soft, irq_s_ext;
    logic redirect, is_u, is_s, is_m;
    priv_types_pkg::priv_level_t priv_level;

    row_t rows[$];
    logic [3:0] irq_now;  // Interrupt levels for rows being added.
    logic [31:0] epcs [5];
    integer seed;
    int errors;
    logic table_built;

    priv_block dut0 (.*);

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    task automatic add_row(input logic exc_v, input logic [4:0] cause_v, input logic [31:0] epc_v,
                           input logic mret_v, input logic sret_v, input logic cv,
                           input priv_types_pkg::csr_op_t op_v, input logic [11:0] addr_v,
                           input logic [31:0] wdata_v, input logic chk_v,
                           input logic [31:0] rdata_v, input logic redir_v,
                           input logic [31:0] pc_v, input priv_types_pkg::priv_level_t lvl_v);
        rows.push_back({exc_v, cause_v, epc_v, mret_v, sret_v, cv, op_v, addr_v, wdata_v,
                        irq_now, chk_v, rdata_v, redir_v, pc_v, lvl_v});
    endtask

    // CSR access only, read value checked.
    task automatic csr_row(input priv_types_pkg::csr_op_t op_v, input logic [11:0] addr_v,
                           input logic [31:0] wdata_v, input logic [31:0] rdata_v,
                           input priv_types_pkg::priv_level_t lvl_v);
        add_row(1'b0, 5'd0, 32'h0, 1'b0, 1'b0, 1'b1, op_v, addr_v, wdata_v, 1'b1, rdata_v,
                1'b0, 32'h0, lvl_v);
    endtask

    task automatic exc_row(input logic [4:0] cause_v, input logic [31:0] epc_v,
                           input logic [31:0] pc_v, input priv_types_pkg::priv_level_t lvl_v);
        add_row(1'b1, cause_v, epc_v, 1'b0, 1'b0, 1'b0, OP_RD, 12'h0, 32'h0, 1'b0, 32'h0,
                1'b1, pc_v, lvl_v);
    endtask

    task automatic ret_row(input logic is_mret, input logic [31:0] pc_v,
                           input priv_types_pkg::priv_level_t lvl_v);
        add_row(1'b0, 5'd0, 32'h0, is_mret, !is_mret, 1'b0, OP_RD, 12'h0, 32'h0, 1'b0, 32'h0,
                1'b1, pc_v, lvl_v);
    endtask

    // No strobe; an enabled interrupt level does the work.
    task automatic intr_row(input logic [31:0] epc_v, input logic [31:0] pc_v,
                            input priv_types_pkg::priv_level_t lvl_v);
        add_row(1'b0, 5'd0, epc_v, 1'b0, 1'b0, 1'b0, OP_RD, 12'h0, 32'h0, 1'b0, 32'h0,
                1'b1, pc_v, lvl_v);
    endtask

    task automatic build_table();
        irq_now = 4'b0000;
        csr_row(OP_RD, `CSR_MTVEC, 32'h0, `RESET_VECTOR, LVL_M);  // Reset value.
        csr_row(OP_RW, `CSR_MTVEC, 32'h0000_0200, `RESET_VECTOR, LVL_M);
        csr_row(OP_RS, `CSR_MTVEC, 32'h0000_0041, 32'h0000_0200, LVL_M);
        csr_row(OP_RC, `CSR_MTVEC, 32'h0000_0001, 32'h0000_0241, LVL_M);
        csr_row(OP_RD, `CSR_MTVEC, 32'h0, 32'h0000_0240, LVL_M);
        csr_row(OP_RW, `CSR_MEPC, 32'h0000_1234, 32'h0, LVL_M);
        csr_row(OP_RS, `CSR_MEPC, 32'h0000_8000, 32'h0000_1234, LVL_M);
        csr_row(OP_RD, `CSR_MEPC, 32'h0, 32'h0000_9234, LVL_M);
        csr_row(OP_RW, `CSR_MEDELEG, 32'h0000_0100, 32'h0, LVL_M);  // Delegate cause 8.
        csr_row(OP_RS, `CSR_MEDELEG, 32'h0000_0010, 32'h0000_0100, LVL_M);
        csr_row(OP_RC, `CSR_MEDELEG, 32'h0000_0010, 32'h0000_0110, LVL_M);
        csr_row(OP_RD, `CSR_MEDELEG, 32'h0, 32'h0000_0100, LVL_M);  // Bit 4 cleared.
        csr_row(OP_RW, `CSR_STVEC, 32'h0000_0803, 32'h0, LVL_M);  // Low bits not in target.
        // Exception in M, then mret down to U.
        exc_row(5'd4, epcs[0], 32'h0000_0240, LVL_M);
        csr_row(OP_RD, `CSR_MEPC, 32'h0, epcs[0], LVL_M);
        csr_row(OP_RD, `CSR_MCAUSE, 32'h0, 32'h0000_0004, LVL_M);
        csr_row(OP_RW, `CSR_MSTATUS, 32'h0, 32'h0000_1800, LVL_M);  // mpp held M.
        ret_row(1'b1, epcs[0], LVL_U);
        // Delegated exception from U, sret back.
        exc_row(5'd8, epcs[1], 32'h0000_0800, LVL_S);
        csr_row(OP_RD, `CSR_SCAUSE, 32'h0, 32'h0000_0008, LVL_S);
        csr_row(OP_RD, `CSR_SEPC, 32'h0, epcs[1], LVL_S);
        ret_row(1'b0, epcs[1], LVL_U);
        // Back to M, then interrupt enables and priority.
        exc_row(5'd3, epcs[2], 32'h0000_0240, LVL_M);
        csr_row(OP_RW, `CSR_MIE, 32'h0000_0888, 32'h0, LVL_M);
        irq_now = 4'b0110;  // Timer and software pending.
        csr_row(OP_RD, `CSR_MIP, 32'h0, 32'h0000_0088, LVL_M);  // Blocked, mie clear.
        csr_row(OP_RS, `CSR_MSTATUS, 32'h0000_0008, 32'h0, LVL_M);
        intr_row(epcs[3], 32'h0000_0240, LVL_M);
        csr_row(OP_RD, `CSR_MCAUSE, 32'h0, 32'h8000_0003, LVL_M);  // Software wins.
        irq_now = 4'b0000;
        csr_row(OP_RD, `CSR_MEPC, 32'h0, epcs[3], LVL_M);
        // Drop to U, then an illegal mtvec write.
        csr_row(OP_RW, `CSR_MSTATUS, 32'h0, 32'h0000_1880, LVL_M);
        ret_row(1'b1, epcs[3], LVL_U);
        add_row(1'b0, 5'd0, epcs[4], 1'b0, 1'b0, 1'b1, OP_RW, `CSR_MTVEC, 32'h0000_0f00,
                1'b0, 32'h0, 1'b1, 32'h0000_0240, LVL_M);
        csr_row(OP_RD, `CSR_MCAUSE, 32'h0, 32'h0000_0002, LVL_M);
        csr_row(OP_RD, `CSR_MTVEC, 32'h0, 32'h0000_0240, LVL_M);  // Old value kept.
        csr_row(OP_RD, `CSR_MEPC, 32'h0, epcs[4], LVL_M);
    endtask

    task automatic apply_row(input row_t r);
        exc = r.exc;
        exc_cause = r.cause;
        epc = r.epc;
        mret = r.mret;
        sret = r.sret;
        csr_valid = r.csr_valid;
        csr_op = r.op;
        csr_addr = r.addr;
        csr_wdata = r.wdata;
        {irq_m_ext, irq_m_timer, irq_m_soft, irq_s_ext} = r.irq;
    endtask

    task automatic drive_idle();
        row_t idle;
        idle = '0;
        apply_row(idle);
    endtask

    task automatic value_error(input int idx, input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        errors++;
        $display("** Error at %0t: %s expected %h, got %h (row %0d)", $time, name, expected,
                 actual, idx);
    endtask

    // Registered outputs, sampled just after the edge.
    task automatic check_outputs(input int idx, input row_t r);
        if (r.exp_redir && redirect !== 1'b1) begin
            errors++;
            $display("Row %0d at %0t: the expected redirect did not arrive", idx, $time);
        end else if (!r.exp_redir && redirect !== 1'b0) begin
            value_error(idx, "redirect", 32'h0, 32'(redirect));
        end else if (r.exp_redir && redirect_pc !== r.exp_pc) begin
            value_error(idx, "redirect_pc", r.exp_pc, redirect_pc);
        end
        if (priv_level !== r.exp_lvl)
            value_error(idx, "priv_level", 32'(r.exp_lvl), 32'(priv_level));
        if (is_u !== (r.exp_lvl == LVL_U))
            value_error(idx, "is_u", 32'(r.exp_lvl == LVL_U), 32'(is_u));
        if (is_s !== (r.exp_lvl == LVL_S))
            value_error(idx, "is_s", 32'(r.exp_lvl == LVL_S), 32'(is_s));
        if (is_m !== (r.exp_lvl == LVL_M))
            value_error(idx, "is_m", 32'(r.exp_lvl == LVL_M), 32'(is_m));
    endtask

    initial begin
        CLK = 1'b0;
        nRST = 1'b0;
        drive_idle();
        errors = 0;
        table_built = 1'b0;
        seed = 32'h2224_d8a1;
        for (int k = 0; k < 5; k++)
            epcs[k] = $random(seed);  // Trap PCs.
        build_table();
        table_built = 1'b1;
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        nRST = 1'b1;
        if (priv_level !== LVL_M)
            value_error(-1, "priv_level", 32'(LVL_M), 32'(priv_level));
        if (is_m !== 1'b1)
            value_error(-1, "is_m", 32'h1, 32'(is_m));
        if (redirect !== 1'b0)
            value_error(-1, "redirect", 32'h0, 32'(redirect));
        foreach (rows[i]) begin
            apply_row(rows[i]);
            #3;  // Let the read mux settle.
            if (rows[i].chk_rdata && csr_rdata !== rows[i].exp_rdata)
                value_error(i, "csr_rdata", rows[i].exp_rdata, csr_rdata);
            @(posedge CLK);
            #1;
            check_outputs(i, rows[i]);
        end
        drive_idle();
        $display("Rows run: %0d, errors: %0d", rows.size(), errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    // Watchdog sized from reset plus table length.
    initial begin
        wait (table_built === 1'b1);
        #((RESET_CYCLES + rows.size() + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: the table did not finish in the expected time");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- files.f
+incdir+hdl
hdl/priv_types_pkg.sv
hdl/priv_mode.sv
hdl/priv_intr_pick.sv
hdl/priv_csr_file.sv
hdl/priv_trap_ctrl.sv
hdl/priv_block.sv
sim/priv_block_tb.sv

//--- Makefile
# Verilator build and run for the privilege unit testbench.

VERILATOR ?= verilator
TOP       ?= priv_block_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary -j 0

SOURCES := $(wildcard hdl/*.sv hdl/*.svh sim/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes.
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Passes only when the pass message shows up in the output.
run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(BUILD_DIR)
